/* srpt_ctrl.sv */
`default_nettype none

module srpt_ctrl (
   input  wire logic                                ap_clk,
   input  wire logic                                ap_rst,
   input  wire logic                                header_avail_i,
   input  wire srpt_grant_pkg::hdr_t                header_data_i,
   output logic                                     header_read_o,
   input  wire logic                                grant_room_i,
   output logic                                     grant_write_o,
   output srpt_grant_pkg::grant_t                   grant_data_o,
   input  wire srpt_grant_pkg::entry_vec_t          entries_i,
   input  wire logic                                match_hit_i,
   input  wire logic [srpt_grant_pkg::SLOT_W-1:0]   match_slot_i,
   input  wire logic                                free_hit_i,
   input  wire logic [srpt_grant_pkg::SLOT_W-1:0]   free_slot_i,
   input  wire logic                                ready_hit_i,
   input  wire logic [srpt_grant_pkg::SLOT_W-1:0]   ready_slot_i,
   output srpt_grant_pkg::table_upd_t               upd_o
);

   import srpt_grant_pkg::*;

   ctrl_state_t        state_q;
   logic [BYTES_W-1:0] budget_q;

   // Header and search results taken at the pop
   hdr_t               hdr_q;
   logic               match_hit_q;
   logic [SLOT_W-1:0]  match_slot_q;
   logic               free_hit_q;
   logic [SLOT_W-1:0]  free_slot_q;

   // Slot chosen at the grant decision
   logic [SLOT_W-1:0]  grant_slot_q;

   entry_t             grant_entry;
   logic [BYTES_W-1:0] grant_bytes;
   logic               first_pkt;
   logic               grant_go;

   // Pop whenever idle and the FIFO is not empty
   assign header_read_o = (state_q == CTRL_IDLE) && header_avail_i;

   // Grants only when no header waits, so headers always win
   assign grant_go = (state_q == CTRL_IDLE) && !header_avail_i && grant_room_i &&
                     ready_hit_i && (budget_q != '0);

   // Table is stable between decision and grant cycle
   assign grant_entry = entries_i[grant_slot_q];

   // Clip to what is left of the budget
   assign grant_bytes = (grant_entry.recv_bytes < budget_q) ? grant_entry.recv_bytes
                                                            : budget_q;

   // Offset zero marks the first packet of a message
   assign first_pkt = (hdr_q.offset == '0);

   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         state_q       <= CTRL_IDLE;
         budget_q      <= BUDGET_BYTES;
         grant_write_o <= 1'b0;
      end else begin
         // Write strobe is a single cycle pulse
         grant_write_o <= 1'b0;
         case (state_q)
            CTRL_IDLE: begin
               if (header_read_o) begin
                  state_q <= CTRL_NEW_HDR;
               end else if (grant_go) begin
                  state_q <= CTRL_GRANT;
               end
            end
            CTRL_NEW_HDR: state_q <= CTRL_IDLE;
            CTRL_GRANT: begin
               state_q       <= CTRL_IDLE;
               budget_q      <= budget_q - grant_bytes;
               grant_write_o <= 1'b1;
            end
            default: state_q <= CTRL_IDLE;
         endcase
      end
   end

   always_ff @(posedge ap_clk) begin
      if (header_read_o) begin
         hdr_q        <= header_data_i;
         match_hit_q  <= match_hit_i;
         match_slot_q <= match_slot_i;
         free_hit_q   <= free_hit_i;
         free_slot_q  <= free_slot_i;
      end
      if (grant_go) begin
         grant_slot_q <= ready_slot_i;
      end
      // Output register, qualified by grant_write_o
      if (state_q == CTRL_GRANT) begin
         grant_data_o.peer        <= grant_entry.peer;
         grant_data_o.rpc         <= grant_entry.rpc;
         grant_data_o.grant_bytes <= grant_bytes;
      end
   end

   // One table update per cycle
   always_comb begin
      upd_o.kind        = UPD_NONE;
      upd_o.slot        = grant_slot_q;
      upd_o.hdr         = hdr_q;
      upd_o.grant_bytes = grant_bytes;
      case (state_q)
         CTRL_NEW_HDR: begin
            // New message needs a free slot and must not exist yet
            if (first_pkt && !match_hit_q && free_hit_q) begin
               upd_o.kind = UPD_INSERT;
               upd_o.slot = free_slot_q;
            end else if (!first_pkt && match_hit_q) begin
               upd_o.kind = UPD_DATA;
               upd_o.slot = match_slot_q;
            end
            // Full table, duplicate start or unknown RPC is dropped
         end
         CTRL_GRANT: upd_o.kind = UPD_GRANT;
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* srpt_grant.f */
srpt_grant_pkg.sv
srpt_match.sv
srpt_select.sv
srpt_table.sv
srpt_ctrl.sv
srpt_grant_top.sv
srpt_grant_properties.sv
srpt_grant_tb.sv

/* srpt_grant_pkg.sv */
`default_nettype none

package srpt_grant_pkg;

   // Number of messages granted at the same time
   localparam int OVERCOMMIT_SLOTS = 8;
   localparam int SLOT_W = 3;

   // Header field widths
   localparam int PEER_W = 14;
   localparam int RPC_W = 16;
   localparam int BYTES_W = 32;

   // Bytes carried by one data packet
   localparam logic [BYTES_W-1:0] PAYLOAD_BYTES = 32'd1386;

   // 60000 RTT bytes times 8 overcommitted messages
   localparam logic [BYTES_W-1:0] BUDGET_BYTES = 32'd480000;

   // Packet header popped from the input FIFO
   typedef struct packed {
      logic [PEER_W-1:0]  peer;
      logic [RPC_W-1:0]   rpc;
      logic [BYTES_W-1:0] offset;
      logic [BYTES_W-1:0] msg_len;
   } hdr_t;

   // One slot of the active table
   typedef struct packed {
      logic               active;
      logic [PEER_W-1:0]  peer;
      logic [RPC_W-1:0]   rpc;
      logic [BYTES_W-1:0] recv_bytes;
      logic [BYTES_W-1:0] grantable_bytes;
   } entry_t;

   typedef entry_t [OVERCOMMIT_SLOTS-1:0] entry_vec_t;

   // Grant written to the output FIFO
   typedef struct packed {
      logic [PEER_W-1:0]  peer;
      logic [RPC_W-1:0]   rpc;
      logic [BYTES_W-1:0] grant_bytes;
   } grant_t;

   // Table operations, one per cycle at most
   typedef enum logic [1:0] {
      UPD_NONE   = 2'd0,
      UPD_INSERT = 2'd1,
      UPD_DATA   = 2'd2,
      UPD_GRANT  = 2'd3
   } upd_kind_t;

   typedef struct packed {
      upd_kind_t          kind;
      logic [SLOT_W-1:0]  slot;
      hdr_t               hdr;
      logic [BYTES_W-1:0] grant_bytes;
   } table_upd_t;

   typedef enum logic [1:0] {
      CTRL_IDLE    = 2'd0,
      CTRL_NEW_HDR = 2'd1,
      CTRL_GRANT   = 2'd2
   } ctrl_state_t;

endpackage

`default_nettype wire

/* srpt_grant_properties.sv */
`default_nettype none

module srpt_grant_properties (
   input wire logic                   ap_clk,
   input wire logic                   ap_rst,
   input wire logic                   header_avail_i,
   input wire logic                   header_read_o,
   input wire logic                   grant_write_o,
   input wire srpt_grant_pkg::grant_t grant_data_o
);

   timeunit 1ns;
   timeprecision 1ps;

   // Failed checks so far, read by the testbench before it ends
   int unsigned fail_count = 0;

   // Pop only with a header at the FIFO head
   pop_needs_header: assert property (@(posedge ap_clk) disable iff (ap_rst)
      header_read_o |-> header_avail_i)
      else begin
         $error("header_read_o high while header_avail_i is low");
         fail_count++;
      end

   // Write strobe lasts one cycle
   write_is_pulse: assert property (@(posedge ap_clk) disable iff (ap_rst)
      grant_write_o |=> !grant_write_o)
      else begin
         $error("grant_write_o high for two cycles in a row");
         fail_count++;
      end

   // An empty grant is never written
   grant_not_empty: assert property (@(posedge ap_clk) disable iff (ap_rst)
      grant_write_o |-> (grant_data_o.grant_bytes != '0))
      else begin
         $error("grant written with zero grant_bytes");
         fail_count++;
      end

   reset_clears_write: assert property (@(posedge ap_clk) ap_rst |=> !grant_write_o)
      else begin
         $error("grant_write_o high right after reset");
         fail_count++;
      end

endmodule

`default_nettype wire

/* srpt_grant_tb.sv */
`default_nettype none

module srpt_grant_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import srpt_grant_pkg::*;

   // Upper bound on headers over all tests
   // Forty cycles for each header plus slack
   localparam int MAX_HEADERS = 512;
   localparam int WATCHDOG_CYCLES = MAX_HEADERS * 40 + 2000;

   logic   ap_clk;
   logic   ap_rst;
   logic   header_avail_i;
   hdr_t   header_data_i;
   logic   header_read_o;
   logic   grant_room_i;
   logic   grant_write_o;
   grant_t grant_data_o;

   // Header FIFO contents with the head at index 0
   hdr_t hdr_fifo[$];
   // First packets sent since the last reset
   hdr_t msgs[$];

   // Reference copy of the table and the byte budget
   logic [OVERCOMMIT_SLOTS-1:0] m_active;
   logic [PEER_W-1:0]  m_peer      [OVERCOMMIT_SLOTS];
   logic [RPC_W-1:0]   m_rpc       [OVERCOMMIT_SLOTS];
   logic [BYTES_W-1:0] m_recv      [OVERCOMMIT_SLOTS];
   logic [BYTES_W-1:0] m_grantable [OVERCOMMIT_SLOTS];
   logic [BYTES_W-1:0] m_budget;
   logic [BYTES_W-1:0] granted_total;

   logic              prev_write;
   logic              prev_read;
   logic [RPC_W-1:0]  next_rpc;

   srpt_grant_top srpt_grant_top_inst (
      .ap_clk         (ap_clk),
      .ap_rst         (ap_rst),
      .header_avail_i (header_avail_i),
      .header_data_i  (header_data_i),
      .header_read_o  (header_read_o),
      .grant_room_i   (grant_room_i),
      .grant_write_o  (grant_write_o),
      .grant_data_o   (grant_data_o)
   );

   bind srpt_grant_top srpt_grant_properties srpt_grant_properties_inst (.*);

   initial begin
      ap_clk = 1'b0;
      forever #10 ap_clk = ~ap_clk;
   end

   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped");
   endtask

   // Fields print as peer/rpc/bytes
   task automatic check_grant(input grant_t got, input grant_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("ERROR %0t grant_data_o got %0d/%0d/%0d expected %0d/%0d/%0d",
            $time, got.peer, got.rpc, got.grant_bytes, exp.peer, exp.rpc, exp.grant_bytes));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("ERROR %0t %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   // SRPT choice on the model or -1 when no grant is allowed
   function automatic int model_pick();
      int best;
      best = -1;
      if (m_budget == '0) begin
         return -1;
      end
      for (int s = 0; s < OVERCOMMIT_SLOTS; s++) begin
         // Strict compare keeps the lowest slot on ties
         if (m_active[s] && (m_recv[s] != '0) &&
             ((best < 0) || (m_grantable[s] < m_grantable[best]))) begin
            best = s;
         end
      end
      return best;
   endfunction

   // Expected grant for the chosen slot clipped to the budget
   function automatic grant_t expected_grant(input int slot);
      grant_t g;
      g.peer = m_peer[slot];
      g.rpc = m_rpc[slot];
      g.grant_bytes = (m_recv[slot] < m_budget) ? m_recv[slot] : m_budget;
      return g;
   endfunction

   task automatic apply_header(input hdr_t h);
      int hit;
      int free_slot;
      hit = -1;
      free_slot = -1;
      // Downward walk leaves the lowest index in both
      for (int s = OVERCOMMIT_SLOTS - 1; s >= 0; s--) begin
         if (m_active[s] && (m_peer[s] == h.peer) && (m_rpc[s] == h.rpc)) begin
            hit = s;
         end
         if (!m_active[s]) begin
            free_slot = s;
         end
      end
      if (h.offset == '0) begin
         // New message is ignored when already known or the table is full
         if ((hit < 0) && (free_slot >= 0)) begin
            m_active[free_slot] = 1'b1;
            m_peer[free_slot] = h.peer;
            m_rpc[free_slot] = h.rpc;
            m_recv[free_slot] = PAYLOAD_BYTES;
            m_grantable[free_slot] = (h.msg_len > PAYLOAD_BYTES) ? h.msg_len - PAYLOAD_BYTES : '0;
         end
      end else if (hit >= 0) begin
         m_recv[hit] = m_recv[hit] + PAYLOAD_BYTES;
         m_grantable[hit] = (m_grantable[hit] > PAYLOAD_BYTES) ?
                            m_grantable[hit] - PAYLOAD_BYTES : '0;
      end
   endtask

   // Grant strobe handled before header strobe at each edge
   always @(posedge ap_clk) begin : compare_proc
      grant_t exp;
      int     slot;
      if (ap_rst) begin
         m_active = '0;
         m_budget = BUDGET_BYTES;
         granted_total = '0;
         prev_write = 1'b0;
         prev_read = 1'b0;
      end else begin
         // Both strobes are single cycle pulses
         if (prev_write) begin
            check_flag("grant_write_o", grant_write_o, 1'b0);
         end
         if (prev_read) begin
            check_flag("header_read_o", header_read_o, 1'b0);
         end
         if (grant_write_o === 1'b1) begin
            slot = model_pick();
            if (slot < 0) begin
               stop_with_failure("A grant was written while nothing was left to grant");
            end else begin
               exp = expected_grant(slot);
               check_grant(grant_data_o, exp);
               m_budget = m_budget - exp.grant_bytes;
               granted_total = granted_total + exp.grant_bytes;
               m_recv[slot] = m_recv[slot] - exp.grant_bytes;
               if ((m_recv[slot] == '0) && (m_grantable[slot] == '0)) begin
                  m_active[slot] = 1'b0;
               end
            end
         end
         if (header_read_o === 1'b1) begin
            apply_header(header_data_i);
         end
         prev_write = grant_write_o;
         prev_read = header_read_o;
      end
   end

   // FIFO model where the head leaves at the pop edge
   always @(posedge ap_clk) begin : header_fifo
      if (header_read_o === 1'b1) begin
         void'(hdr_fifo.pop_front());
      end
      if (hdr_fifo.size() != 0) begin
         header_avail_i <= 1'b1;
         header_data_i <= hdr_fifo[0];
      end else begin
         header_avail_i <= 1'b0;
         header_data_i <= '0;
      end
   end

   task automatic push_hdr(input hdr_t h);
      @(negedge ap_clk);
      hdr_fifo.push_back(h);
   endtask

   task automatic start_message(input logic [BYTES_W-1:0] len);
      hdr_t h;
      h.peer = PEER_W'($urandom);
      h.rpc = next_rpc;
      h.offset = '0;
      h.msg_len = len;
      next_rpc = next_rpc + 1'b1;
      msgs.push_back(h);
      push_hdr(h);
   endtask

   // Later packet of a known message at some nonzero offset
   task automatic send_data(input int idx);
      hdr_t h;
      h = msgs[idx];
      h.offset = PAYLOAD_BYTES * (1 + $urandom_range(20));
      push_hdr(h);
   endtask

   task automatic set_room(input logic level);
      @(posedge ap_clk);
      grant_room_i <= level;
   endtask

   task automatic apply_reset();
      @(posedge ap_clk);
      ap_rst <= 1'b1;
      repeat (3) @(posedge ap_clk);
      ap_rst <= 1'b0;
      msgs.delete();
   endtask

   // Runs until the FIFO is empty and the model has nothing to grant
   task automatic drain_grants(input bit random_room);
      bit done;
      done = 1'b0;
      while (!done) begin
         @(posedge ap_clk);
         grant_room_i <= random_room ? ($urandom_range(3) != 0) : 1'b1;
         @(negedge ap_clk);
         done = (hdr_fifo.size() == 0) && !header_avail_i && (model_pick() < 0);
      end
   endtask

   // Room is open yet neither strobe may rise
   task automatic quiet_cycles(input int n);
      repeat (n) begin
         @(posedge ap_clk);
         grant_room_i <= 1'b1;
         @(negedge ap_clk);
         check_flag("header_read_o", header_read_o, 1'b0);
         check_flag("grant_write_o", grant_write_o, 1'b0);
      end
   endtask

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
      stop_with_failure("Timeout, an expected grant never appeared");
   end

   initial begin : stimulus
      hdr_t h;
      ap_rst = 1'b1;
      header_avail_i = 1'b0;
      header_data_i = '0;
      grant_room_i = 1'b0;
      void'($urandom(32'hb423));
      next_rpc = 16'd1;
      repeat (3) @(posedge ap_clk);
      ap_rst <= 1'b0;

      // Nothing happens with an empty FIFO
      quiet_cycles(20);

      // First packets alone grant one payload each
      for (int i = 0; i < 6; i++) begin
         start_message(32'd1 + $urandom_range(60000));
         drain_grants(1'b0);
      end

      // Mixed traffic held back and then released in SRPT order
      apply_reset();
      set_room(1'b0);
      for (int i = 0; i < 5; i++) begin
         start_message(PAYLOAD_BYTES * (2 + $urandom_range(30)));
      end
      // Same length as message 0 for a tie
      start_message(msgs[0].msg_len);
      for (int i = 0; i < 24; i++) begin
         send_data($urandom_range(msgs.size() - 1));
      end
      drain_grants(1'b1);

      // Full table, duplicate start and unknown RPC
      apply_reset();
      set_room(1'b0);
      for (int i = 0; i < 7; i++) begin
         start_message(PAYLOAD_BYTES * (4 + $urandom_range(40)));
      end
      // Duplicate start while slot 7 is still free
      push_hdr(msgs[2]);
      start_message(PAYLOAD_BYTES * (4 + $urandom_range(40)));
      start_message(32'd50000);
      h = msgs[0];
      h.rpc = 16'hffff;
      h.offset = PAYLOAD_BYTES;
      push_hdr(h);
      for (int i = 0; i < 12; i++) begin
         send_data($urandom_range(7));
      end
      drain_grants(1'b1);

      // Short messages free their slots for later ones
      apply_reset();
      for (int i = 0; i < 8; i++) begin
         start_message(32'd1 + $urandom_range(1385));
      end
      drain_grants(1'b0);
      start_message(PAYLOAD_BYTES * 3);
      send_data(8);
      send_data(8);
      drain_grants(1'b0);
      for (int i = 0; i < 8; i++) begin
         start_message(PAYLOAD_BYTES * (2 + $urandom_range(20)));
      end
      drain_grants(1'b1);

      // Enough data to use up the whole budget
      apply_reset();
      set_room(1'b0);
      start_message(32'd2000000);
      start_message(32'd600000);
      for (int i = 0; i < BUDGET_BYTES / PAYLOAD_BYTES + 4; i++) begin
         send_data(i % 2);
      end
      drain_grants(1'b0);
      quiet_cycles(40);
      if (granted_total != BUDGET_BYTES) begin
         stop_with_failure($sformatf("Grants added up to %0d bytes, not the full budget",
                                     granted_total));
      end

      if (srpt_grant_top_inst.srpt_grant_properties_inst.fail_count != 0) begin
         stop_with_failure("A bound assertion failed during the run");
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* srpt_grant_top.sv */
`default_nettype none

module srpt_grant_top (
   input  wire logic                     ap_clk,
   input  wire logic                     ap_rst,
   input  wire logic                     header_avail_i,
   input  wire srpt_grant_pkg::hdr_t     header_data_i,
   output logic                          header_read_o,
   input  wire logic                     grant_room_i,
   output logic                          grant_write_o,
   output srpt_grant_pkg::grant_t        grant_data_o
);

   import srpt_grant_pkg::*;

   // Table contents seen by both searches
   entry_vec_t        entries;

   // Header search results
   logic              match_hit;
   logic [SLOT_W-1:0] match_slot;
   logic              free_hit;
   logic [SLOT_W-1:0] free_slot;

   // SRPT winner
   logic              ready_hit;
   logic [SLOT_W-1:0] ready_slot;

   table_upd_t        upd;

   srpt_table srpt_table_inst (
      .ap_clk    (ap_clk),
      .ap_rst    (ap_rst),
      .upd_i     (upd),
      .entries_o (entries)
   );

   // Searched with the FIFO head before the pop
   srpt_match srpt_match_inst (
      .entries_i    (entries),
      .hdr_i        (header_data_i),
      .match_hit_o  (match_hit),
      .match_slot_o (match_slot),
      .free_hit_o   (free_hit),
      .free_slot_o  (free_slot)
   );

   srpt_select srpt_select_inst (
      .entries_i    (entries),
      .ready_hit_o  (ready_hit),
      .ready_slot_o (ready_slot)
   );

   srpt_ctrl srpt_ctrl_inst (
      .ap_clk         (ap_clk),
      .ap_rst         (ap_rst),
      .header_avail_i (header_avail_i),
      .header_data_i  (header_data_i),
      .header_read_o  (header_read_o),
      .grant_room_i   (grant_room_i),
      .grant_write_o  (grant_write_o),
      .grant_data_o   (grant_data_o),
      .entries_i      (entries),
      .match_hit_i    (match_hit),
      .match_slot_i   (match_slot),
      .free_hit_i     (free_hit),
      .free_slot_i    (free_slot),
      .ready_hit_i    (ready_hit),
      .ready_slot_i   (ready_slot),
      .upd_o          (upd)
   );

endmodule

`default_nettype wire

/* srpt_match.sv */
`default_nettype none

module srpt_match (
   input  wire srpt_grant_pkg::entry_vec_t     entries_i,
   input  wire srpt_grant_pkg::hdr_t           hdr_i,
   output logic                                match_hit_o,
   output logic [srpt_grant_pkg::SLOT_W-1:0]   match_slot_o,
   output logic                                free_hit_o,
   output logic [srpt_grant_pkg::SLOT_W-1:0]   free_slot_o
);

   import srpt_grant_pkg::*;

   // One bit per slot for each search
   logic [OVERCOMMIT_SLOTS-1:0] rpc_eq;
   logic [OVERCOMMIT_SLOTS-1:0] slot_free;

   // Compare the header against every slot in parallel
   always_comb begin
      for (int s = 0; s < OVERCOMMIT_SLOTS; s++) begin
         // Both peer and RPC must match, and only live slots count
         rpc_eq[s] = entries_i[s].active &&
                     (entries_i[s].peer == hdr_i.peer) &&
                     (entries_i[s].rpc == hdr_i.rpc);
         slot_free[s] = !entries_i[s].active;
      end
   end

   // Priority encode the match vector, lowest slot wins
   always_comb begin
      match_hit_o  = 1'b0;
      match_slot_o = '0;
      // Walk downward so the last hit written is the lowest slot
      for (int s = OVERCOMMIT_SLOTS - 1; s >= 0; s--) begin
         if (rpc_eq[s]) begin
            match_hit_o  = 1'b1;
            match_slot_o = SLOT_W'(s);
         end
      end
   end

   // Lowest empty slot takes the next new message
   always_comb begin
      free_hit_o  = 1'b0;
      free_slot_o = '0;
      for (int s = OVERCOMMIT_SLOTS - 1; s >= 0; s--) begin
         if (slot_free[s]) begin
            free_hit_o  = 1'b1;
            free_slot_o = SLOT_W'(s);
         end
      end
   end

endmodule

`default_nettype wire

/* srpt_select.sv */
`default_nettype none

module srpt_select (
   input  wire srpt_grant_pkg::entry_vec_t     entries_i,
   output logic                                ready_hit_o,
   output logic [srpt_grant_pkg::SLOT_W-1:0]   ready_slot_o
);

   import srpt_grant_pkg::*;

   // Candidate carried up the comparator tree
   typedef struct packed {
      logic               valid;
      logic [SLOT_W-1:0]  slot;
      logic [BYTES_W-1:0] grantable;
   } cand_t;

   // Heap layout, node n has children 2n+1 and 2n+2
   // Leaves sit at OVERCOMMIT_SLOTS-1 and up, in slot order
   cand_t node [2*OVERCOMMIT_SLOTS-1];

   // Keep the shorter remaining message
   // Left input always covers lower slots, so it keeps ties
   function automatic cand_t pick(input cand_t lo, input cand_t hi);
      if (lo.valid && (!hi.valid || (lo.grantable <= hi.grantable))) begin
         return lo;
      end
      return hi;
   endfunction

   genvar s;
   genvar n;

   // Leaves, one per slot
   generate
      for (s = 0; s < OVERCOMMIT_SLOTS; s++) begin : g_leaf
         // Ready means live and holding received bytes not yet granted
         assign node[OVERCOMMIT_SLOTS-1+s].valid =
            entries_i[s].active && (entries_i[s].recv_bytes != '0);
         assign node[OVERCOMMIT_SLOTS-1+s].slot = SLOT_W'(s);
         assign node[OVERCOMMIT_SLOTS-1+s].grantable = entries_i[s].grantable_bytes;
      end
   endgenerate

   // Inner comparators, log2 levels deep
   generate
      for (n = 0; n < OVERCOMMIT_SLOTS - 1; n++) begin : g_node
         assign node[n] = pick(node[2*n+1], node[2*n+2]);
      end
   endgenerate

   // Root holds the SRPT winner
   assign ready_hit_o  = node[0].valid;
   assign ready_slot_o = node[0].slot;

endmodule

`default_nettype wire

/* srpt_table.sv */
`default_nettype none

module srpt_table (
   input  wire logic                        ap_clk,
   input  wire logic                        ap_rst,
   input  wire srpt_grant_pkg::table_upd_t  upd_i,
   output srpt_grant_pkg::entry_vec_t       entries_o
);

   import srpt_grant_pkg::*;

   // Slot valid flags
   logic [OVERCOMMIT_SLOTS-1:0] active_q;

   // Slot contents
   logic [PEER_W-1:0]  peer_q      [OVERCOMMIT_SLOTS];
   logic [RPC_W-1:0]   rpc_q       [OVERCOMMIT_SLOTS];
   logic [BYTES_W-1:0] recv_q      [OVERCOMMIT_SLOTS];
   logic [BYTES_W-1:0] grantable_q [OVERCOMMIT_SLOTS];

   // Current counts of the addressed slot
   logic [BYTES_W-1:0] sel_recv;
   logic [BYTES_W-1:0] sel_grantable;

   // Next values per update kind
   logic [BYTES_W-1:0] ins_grantable;
   logic [BYTES_W-1:0] data_recv;
   logic [BYTES_W-1:0] data_grantable;
   logic [BYTES_W-1:0] grant_recv;
   logic               grant_done;

   assign sel_recv      = recv_q[upd_i.slot];
   assign sel_grantable = grantable_q[upd_i.slot];

   always_comb begin
      // First packet already carried one payload
      if (upd_i.hdr.msg_len > PAYLOAD_BYTES) begin
         ins_grantable = upd_i.hdr.msg_len - PAYLOAD_BYTES;
      end else begin
         ins_grantable = '0;
      end

      // Data packet moves one payload from grantable to received
      data_recv = sel_recv + PAYLOAD_BYTES;
      if (sel_grantable > PAYLOAD_BYTES) begin
         data_grantable = sel_grantable - PAYLOAD_BYTES;
      end else begin
         data_grantable = '0;
      end

      // Grant takes at most the received bytes
      grant_recv = sel_recv - upd_i.grant_bytes;

      // Fully granted message frees its slot
      grant_done = (grant_recv == '0) && (sel_grantable == '0);
   end

   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         active_q <= '0;
      end else begin
         case (upd_i.kind)
            UPD_INSERT: active_q[upd_i.slot] <= 1'b1;
            UPD_GRANT: begin
               if (grant_done) begin
                  active_q[upd_i.slot] <= 1'b0;
               end
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge ap_clk) begin
      case (upd_i.kind)
         UPD_INSERT: begin
            peer_q[upd_i.slot]      <= upd_i.hdr.peer;
            rpc_q[upd_i.slot]       <= upd_i.hdr.rpc;
            recv_q[upd_i.slot]      <= PAYLOAD_BYTES;
            grantable_q[upd_i.slot] <= ins_grantable;
         end
         UPD_DATA: begin
            recv_q[upd_i.slot]      <= data_recv;
            grantable_q[upd_i.slot] <= data_grantable;
         end
         UPD_GRANT: recv_q[upd_i.slot] <= grant_recv;
         default: ;
      endcase
   end

   // Present the slots as one packed vector
   always_comb begin
      for (int s = 0; s < OVERCOMMIT_SLOTS; s++) begin
         entries_o[s].active          = active_q[s];
         entries_o[s].peer            = peer_q[s];
         entries_o[s].rpc             = rpc_q[s];
         entries_o[s].recv_bytes      = recv_q[s];
         entries_o[s].grantable_bytes = grantable_q[s];
      end
   end

endmodule

`default_nettype wire
